/* sim.f */
+incdir+src
src/issue_pkg.sv
src/issue_ibuffer.sv
src/issue_scoreboard.sv
src/issue_operands.sv
src/issue_dispatch.sv
src/issue_top.sv
test/issue_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the issue stage testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f sim.f --top-module issue_tb -o issue_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

sim_output=$(./obj_dir/issue_sim)
sim_status=$?
echo "$sim_output"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_output" | grep -qx "SIMULATION PASSED"; then
    exit 0
fi
exit 1

/* test/issue_cases.txt */
# W wid rd data (driven once the instruction that owns rd has been dispatched)
# I uuid wid ex(0 alu, 1 lsu) op wb rd rs1 rs2 exp_rs1 exp_rs2 wait_uuid (ff for none)
W 0 01 11110001
W 0 02 22220002
W 1 01 11110101
W 1 02 22220102
W 2 01 11110201
W 2 02 22220202
W 3 01 11110301
W 3 02 22220302
I 01 0 0 1 0 00 01 02 11110001 22220002 ff
I 02 1 1 2 0 00 02 01 22220102 11110101 ff
I 03 2 1 3 0 00 01 01 11110201 11110201 ff
I 04 3 0 4 0 00 02 02 22220302 22220302 ff
I 05 0 0 5 1 05 01 02 11110001 22220002 ff
I 06 0 1 6 0 00 05 01 5555a005 11110001 ff
W 0 05 5555a005
I 07 2 0 7 1 07 01 02 11110201 22220202 ff
I 08 2 1 8 1 07 02 01 22220202 11110201 ff
I 09 3 1 9 0 00 01 02 11110301 22220302 ff
W 2 07 7777b007
W 2 07 7777c007
I 0a 2 0 a 0 00 07 07 7777c007 7777c007 ff
I 10 1 0 1 1 04 01 02 11110101 22220102 ff
I 11 1 1 2 1 03 04 01 4444d004 11110101 ff
I 12 1 0 3 0 00 03 02 3333e003 22220102 ff
I 13 1 1 4 0 00 01 02 11110101 22220102 ff
I 14 1 0 5 0 00 02 01 22220102 11110101 ff
I 15 1 1 6 0 00 01 01 11110101 11110101 ff
I 16 1 0 7 0 00 02 02 22220102 22220102 ff
W 1 04 4444d004
W 1 03 3333e003
I 17 3 1 8 0 00 01 02 11110301 22220302 16

/* test/issue_tb.sv */
`timescale 1ns/100ps
`default_nettype none

`include "issue_macros.svh"

module issue_tb;
    localparam int MAX_RECS = 48;

    logic                  clk;
    logic                  reset;
    logic                  decode_valid;
    issue_pkg::decode_t    decode_data;
    logic                  decode_ready;
    logic                  writeback_valid;
    issue_pkg::writeback_t writeback_data;
    logic                  alu_valid;
    issue_pkg::operands_t  alu_data;
    logic                  alu_ready;
    logic                  lsu_valid;
    issue_pkg::operands_t  lsu_data;
    logic                  lsu_ready;

    integer seed;
    int     n_recs;
    int     i_sent;
    int     w_done;
    int     stalls;
    int     checked;
    int     errors;

    // Parsed records, indexed in file order
    bit                          rec_is_i   [MAX_RECS];
    issue_pkg::decode_t          rec_instr  [MAX_RECS];
    issue_pkg::writeback_t       rec_wb     [MAX_RECS];
    logic [`ISSUE_XLEN-1:0]      rec_exp1   [MAX_RECS];
    logic [`ISSUE_XLEN-1:0]      rec_exp2   [MAX_RECS];
    logic [`ISSUE_UUID_BITS-1:0] rec_wait   [MAX_RECS];
    int                          rec_before [MAX_RECS];
    bit                          claimed    [MAX_RECS];
    bit                          dispatched [2**`ISSUE_UUID_BITS];

    // Writers of each register numbered in send order, and how many have written back
    int wb_sent [`ISSUE_WARPS][`ISSUE_REGS];
    int wb_done [`ISSUE_WARPS][`ISSUE_REGS];
    int wr_seq  [2**`ISSUE_UUID_BITS];

    logic [`ISSUE_XLEN-1:0] reg_model [`ISSUE_WARPS][`ISSUE_REGS];
    issue_pkg::operands_t   alu_exp [$];
    issue_pkg::operands_t   lsu_exp [$];

    issue_top issue_top_i (
        .clk             (clk),
        .reset           (reset),
        .decode_valid    (decode_valid),
        .decode_data     (decode_data),
        .decode_ready    (decode_ready),
        .writeback_valid (writeback_valid),
        .writeback_data  (writeback_data),
        .alu_valid       (alu_valid),
        .alu_data        (alu_data),
        .alu_ready       (alu_ready),
        .lsu_valid       (lsu_valid),
        .lsu_data        (lsu_data),
        .lsu_ready       (lsu_ready)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic load_cases();
        int         fd;
        int         code;
        int         c;
        int         i_count;
        int         w_count;
        logic [7:0] kind;
        logic [31:0] f [11];
        i_count = 0;
        w_count = 0;
        fd = $fopen("test/issue_cases.txt", "r");
        if (fd == 0) begin
            $display("cannot open test/issue_cases.txt");
            return;
        end
        while (n_recs < MAX_RECS && $fscanf(fd, " %c", kind) == 1) begin
            if (kind == "#") begin
                c = $fgetc(fd);
                while (c != "\n" && c != -1) c = $fgetc(fd);
            end else if (kind == "W") begin
                code = $fscanf(fd, " %h %h %h", f[0], f[1], f[2]);
                if (code != 3) begin
                    $display("malformed W record after record %0d", n_recs);
                    errors++;
                end
                rec_is_i[n_recs] = 1'b0;
                rec_wb[n_recs] = {f[0][`ISSUE_WARP_BITS-1:0], f[1][`ISSUE_REG_BITS-1:0], f[2]};
                rec_before[n_recs] = i_count;
                rec_wait[n_recs] = '1;
                // The writeback belongs to the oldest unclaimed writer of that register
                for (int j = 0; j < n_recs; j++) begin
                    if (rec_is_i[j] && !claimed[j] && rec_instr[j].wb
                        && rec_instr[j].wid == rec_wb[n_recs].wid
                        && rec_instr[j].rd == rec_wb[n_recs].rd) begin
                        claimed[j] = 1'b1;
                        rec_wait[n_recs] = rec_instr[j].uuid;
                        break;
                    end
                end
                w_count++;
                n_recs++;
            end else if (kind == "I") begin
                code = $fscanf(fd, " %h %h %h %h %h %h %h %h %h %h %h", f[0], f[1], f[2],
                               f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10]);
                if (code != 11) begin
                    $display("malformed I record after record %0d", n_recs);
                    errors++;
                end
                rec_is_i[n_recs] = 1'b1;
                rec_instr[n_recs].uuid    = f[0][`ISSUE_UUID_BITS-1:0];
                rec_instr[n_recs].wid     = f[1][`ISSUE_WARP_BITS-1:0];
                rec_instr[n_recs].ex_type = issue_pkg::ex_type_t'(f[2][0]);
                rec_instr[n_recs].op_type = f[3][3:0];
                rec_instr[n_recs].wb      = f[4][0];
                rec_instr[n_recs].rd      = f[5][`ISSUE_REG_BITS-1:0];
                rec_instr[n_recs].rs1     = f[6][`ISSUE_REG_BITS-1:0];
                rec_instr[n_recs].rs2     = f[7][`ISSUE_REG_BITS-1:0];
                rec_exp1[n_recs] = f[8];
                rec_exp2[n_recs] = f[9];
                rec_wait[n_recs] = f[10][`ISSUE_UUID_BITS-1:0];
                rec_before[n_recs] = w_count;
                i_count++;
                n_recs++;
            end else begin
                $display("unknown record type %c in case file", kind);
                errors++;
            end
        end
        $fclose(fd);
    endtask

    task automatic check_operands(input string unit, input issue_pkg::operands_t exp,
                                  input issue_pkg::operands_t got);
        if (got.instr !== exp.instr) begin
            $display("MISMATCH %s_data.instr exp %h got %h", unit, exp.instr, got.instr);
            errors++;
        end
        if (got.rs1_data !== exp.rs1_data) begin
            $display("MISMATCH %s_data.rs1_data exp %h got %h", unit, exp.rs1_data,
                     got.rs1_data);
            errors++;
        end
        if (got.rs2_data !== exp.rs2_data) begin
            $display("MISMATCH %s_data.rs2_data exp %h got %h", unit, exp.rs2_data,
                     got.rs2_data);
            errors++;
        end
    endtask

    // Match a dispatched instruction against the oldest entry of its warp for that unit
    task automatic take_dispatch(input bit is_lsu, input issue_pkg::operands_t got);
        issue_pkg::operands_t exp;
        string                unit;
        int                   idx;
        int                   err_before;
        unit = is_lsu ? "lsu" : "alu";
        idx = -1;
        err_before = errors;
        if (dispatched[got.instr.uuid]) begin
            $display("uuid %h was dispatched a second time on %s", got.instr.uuid, unit);
            errors++;
            return;
        end
        if (is_lsu) begin
            for (int i = 0; i < lsu_exp.size(); i++)
                if (idx < 0 && lsu_exp[i].instr.wid == got.instr.wid) idx = i;
        end else begin
            for (int i = 0; i < alu_exp.size(); i++)
                if (idx < 0 && alu_exp[i].instr.wid == got.instr.wid) idx = i;
        end
        if (idx < 0) begin
            $display("unexpected %s dispatch of uuid %h from warp %0d", unit,
                     got.instr.uuid, got.instr.wid);
            errors++;
            return;
        end
        if (is_lsu) begin
            exp = lsu_exp[idx];
            lsu_exp.delete(idx);
        end else begin
            exp = alu_exp[idx];
            alu_exp.delete(idx);
        end
        dispatched[got.instr.uuid] = 1'b1;
        check_operands(unit, exp, got);
        if (exp.rs1_data !== reg_model[exp.instr.wid][exp.instr.rs1]
            || exp.rs2_data !== reg_model[exp.instr.wid][exp.instr.rs2]) begin
            $display("case file operands of uuid %h disagree with the register model",
                     exp.instr.uuid);
            errors++;
        end
        // A second writer of a register may only leave once every older write has landed
        if (exp.instr.wb
            && wb_done[exp.instr.wid][exp.instr.rd] != wr_seq[exp.instr.uuid]) begin
            $display("uuid %h left while an older write of warp %0d register %0d was owed",
                     exp.instr.uuid, exp.instr.wid, exp.instr.rd);
            errors++;
        end
        checked++;
        $display("uuid %h warp %0d %s %s", got.instr.uuid, got.instr.wid, unit,
                 (errors == err_before) ? "ok" : "wrong");
    endtask

    task automatic send_instr(input int k);
        issue_pkg::operands_t exp;
        logic                 accepted;
        while (w_done < rec_before[k]
               || (rec_wait[k] != '1 && !dispatched[rec_wait[k]])) begin
            @(posedge clk);
            #1;
        end
        decode_valid = 1'b1;
        decode_data  = rec_instr[k];
        accepted = 1'b0;
        while (!accepted) begin
            @(negedge clk);
            accepted = decode_ready;
            @(posedge clk);
            #1;
            if (!accepted) stalls++;
        end
        decode_valid = 1'b0;
        if (rec_instr[k].wb) begin
            wr_seq[rec_instr[k].uuid] = wb_sent[rec_instr[k].wid][rec_instr[k].rd];
            wb_sent[rec_instr[k].wid][rec_instr[k].rd]++;
        end
        exp.instr    = rec_instr[k];
        exp.rs1_data = rec_exp1[k];
        exp.rs2_data = rec_exp2[k];
        if (rec_instr[k].ex_type == issue_pkg::EX_LSU) lsu_exp.push_back(exp);
        else alu_exp.push_back(exp);
        i_sent++;
    endtask

    // A writeback with an owner models that unit finishing after dispatch
    task automatic drive_writeback(input int k);
        while ((rec_wait[k] == '1) ? (i_sent < rec_before[k]) : !dispatched[rec_wait[k]]) begin
            @(posedge clk);
            #1;
        end
        writeback_valid = 1'b1;
        writeback_data  = rec_wb[k];
        reg_model[rec_wb[k].wid][rec_wb[k].rd] = rec_wb[k].data;
        @(posedge clk);
        #1;
        writeback_valid = 1'b0;
        if (rec_wait[k] != '1) begin
            wb_done[rec_wb[k].wid][rec_wb[k].rd]++;
        end
        w_done++;
    endtask

    task automatic send_all();
        for (int k = 0; k < n_recs; k++)
            if (rec_is_i[k]) send_instr(k);
    endtask

    task automatic drive_all_writebacks();
        for (int k = 0; k < n_recs; k++)
            if (!rec_is_i[k]) drive_writeback(k);
    endtask

    task automatic print_counts();
        $display("%0d instructions checked, %0d errors, %0d missing dispatches, %0d decode stalls",
                 checked, errors, alu_exp.size() + lsu_exp.size(), stalls);
    endtask

    always @(negedge clk) begin
        if (!reset && alu_valid && alu_ready) take_dispatch(1'b0, alu_data);
        if (!reset && lsu_valid && lsu_ready) take_dispatch(1'b1, lsu_data);
    end

    // Random back-pressure on both unit ports
    initial begin
        forever begin
            @(posedge clk);
            #1;
            alu_ready = (($random(seed) & 3) != 0);
            lsu_ready = (($random(seed) & 3) != 0);
        end
    end

    initial begin
        wait (n_recs > 0);
        repeat (n_recs * 200) @(posedge clk);
        $display("timeout after %0d cycles, %0d dispatches never arrived", n_recs * 200,
                 alu_exp.size() + lsu_exp.size());
        print_counts();
        $display("SIMULATION FAILED");
        $finish;
    end

    initial begin
        seed            = 32'hb95c;
        reset           = 1'b1;
        decode_valid    = 1'b0;
        decode_data     = '0;
        writeback_valid = 1'b0;
        writeback_data  = '0;
        alu_ready       = 1'b0;
        lsu_ready       = 1'b0;
        load_cases();
        repeat (16) @(posedge clk);
        #1;
        reset = 1'b0;
        if (n_recs == 0) begin
            $display("no records were read from the case file");
            errors++;
        end else begin
            fork
                send_all();
                drive_all_writebacks();
            join
            while (alu_exp.size() + lsu_exp.size() != 0) begin
                @(posedge clk);
                #1;
            end
            // Leave time for a duplicate dispatch to show up
            repeat (10) @(posedge clk);
            if (stalls == 0) begin
                $display("decode_ready never dropped although a warp FIFO was filled");
                errors++;
            end
        end
        print_counts();
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* src/issue_top.sv */
`timescale 1ns/100ps
`default_nettype none

`include "issue_macros.svh"

module issue_top (
    input  wire                   clk,
    input  wire                   reset,

    input  wire                   decode_valid,
    input  issue_pkg::decode_t    decode_data,
    output logic                  decode_ready,

    input  wire                   writeback_valid,
    input  issue_pkg::writeback_t writeback_data,

    output logic                  alu_valid,
    output issue_pkg::operands_t  alu_data,
    input  wire                   alu_ready,

    output logic                  lsu_valid,
    output issue_pkg::operands_t  lsu_data,
    input  wire                   lsu_ready
);
    // Warp FIFO heads
    logic [`ISSUE_WARPS-1:0] head_valid;
    issue_pkg::decode_t      head_data [`ISSUE_WARPS];
    logic [`ISSUE_WARPS-1:0] head_ready;

    logic                    sched_valid;
    issue_pkg::decode_t      sched_data;
    logic                    sched_ready;

    logic                    opd_valid;
    issue_pkg::operands_t    opd_data;
    logic                    opd_ready;

    issue_ibuffer ibuffer_i (
        .clk          (clk),
        .reset        (reset),
        .decode_valid (decode_valid),
        .decode_data  (decode_data),
        .decode_ready (decode_ready),
        .head_valid   (head_valid),
        .head_data    (head_data),
        .head_ready   (head_ready)
    );

    // Writeback fans out to the scoreboard and the register file
    issue_scoreboard scoreboard_i (
        .clk             (clk),
        .reset           (reset),
        .head_valid      (head_valid),
        .head_data       (head_data),
        .head_ready      (head_ready),
        .writeback_valid (writeback_valid),
        .writeback_data  (writeback_data),
        .sched_valid     (sched_valid),
        .sched_data      (sched_data),
        .sched_ready     (sched_ready)
    );

    issue_operands operands_i (
        .clk             (clk),
        .reset           (reset),
        .sched_valid     (sched_valid),
        .sched_data      (sched_data),
        .sched_ready     (sched_ready),
        .writeback_valid (writeback_valid),
        .writeback_data  (writeback_data),
        .opd_valid       (opd_valid),
        .opd_data        (opd_data),
        .opd_ready       (opd_ready)
    );

    issue_dispatch dispatch_i (
        .clk       (clk),
        .reset     (reset),
        .opd_valid (opd_valid),
        .opd_data  (opd_data),
        .opd_ready (opd_ready),
        .alu_valid (alu_valid),
        .alu_data  (alu_data),
        .alu_ready (alu_ready),
        .lsu_valid (lsu_valid),
        .lsu_data  (lsu_data),
        .lsu_ready (lsu_ready)
    );

endmodule

`default_nettype wire

/* src/issue_dispatch.sv */
`timescale 1ns/100ps
`default_nettype none

`include "issue_macros.svh"

module issue_dispatch (
    input  wire                  clk,
    input  wire                  reset,

    input  wire                  opd_valid,
    input  issue_pkg::operands_t opd_data,
    output logic                 opd_ready,

    output logic                 alu_valid,
    output issue_pkg::operands_t alu_data,
    input  wire                  alu_ready,

    output logic                 lsu_valid,
    output issue_pkg::operands_t lsu_data,
    input  wire                  lsu_ready
);
    // Slot index is the ex_type encoding, ALU in slot 0 and LSU in slot 1
    logic [1:0]           slot_valid;
    logic [1:0]           slot_ready;
    logic [1:0]           slot_load;
    issue_pkg::operands_t slot_data [2];
    issue_pkg::ex_type_t  target;

    assign target     = opd_data.instr.ex_type;
    assign slot_ready = {lsu_ready, alu_ready};

    // Only the selected unit's slot decides whether the instruction moves
    assign opd_ready = !slot_valid[target] || slot_ready[target];

    always_comb begin
        for (int u = 0; u < 2; u++) begin
            slot_load[u] = opd_valid && opd_ready && (target == u);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            slot_valid <= '0;
        end else begin
            for (int u = 0; u < 2; u++) begin
                if (slot_load[u]) begin
                    slot_valid[u] <= 1'b1;
                end else if (slot_ready[u]) begin
                    slot_valid[u] <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int u = 0; u < 2; u++) begin
            if (slot_load[u]) begin
                slot_data[u] <= opd_data;
            end
        end
    end

    assign alu_valid = slot_valid[issue_pkg::EX_ALU];
    assign alu_data  = slot_data[issue_pkg::EX_ALU];
    assign lsu_valid = slot_valid[issue_pkg::EX_LSU];
    assign lsu_data  = slot_data[issue_pkg::EX_LSU];

endmodule

`default_nettype wire

/* src/issue_operands.sv */
`timescale 1ns/100ps
`default_nettype none

`include "issue_macros.svh"

module issue_operands (
    input  wire                   clk,
    input  wire                   reset,

    input  wire                   sched_valid,
    input  issue_pkg::decode_t    sched_data,
    output logic                  sched_ready,

    input  wire                   writeback_valid,
    input  issue_pkg::writeback_t writeback_data,

    output logic                  opd_valid,
    output issue_pkg::operands_t  opd_data,
    input  wire                   opd_ready
);
    localparam int ADDR_BITS = `ISSUE_WARP_BITS + `ISSUE_REG_BITS;

    // One flat array, addressed by {warp, register}
    logic [`ISSUE_XLEN-1:0] rf [`ISSUE_WARPS * `ISSUE_REGS];

    logic [ADDR_BITS-1:0] wr_addr;
    logic [ADDR_BITS-1:0] rs1_addr;
    logic [ADDR_BITS-1:0] rs2_addr;
    logic                 load;

    assign wr_addr  = {writeback_data.wid, writeback_data.rd};
    assign rs1_addr = {sched_data.wid, sched_data.rs1};
    assign rs2_addr = {sched_data.wid, sched_data.rs2};

    assign sched_ready = !opd_valid || opd_ready;
    assign load = sched_valid && sched_ready;

    // Write port
    always_ff @(posedge clk) begin
        if (writeback_valid) begin
            rf[wr_addr] <= writeback_data.data;
        end
    end

    // The scoreboard holds any reader until its writeback has landed,
    // so the synchronous read always returns committed data
    always_ff @(posedge clk) begin
        if (load) begin
            opd_data.instr    <= sched_data;
            opd_data.rs1_data <= rf[rs1_addr];
            opd_data.rs2_data <= rf[rs2_addr];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            opd_valid <= 1'b0;
        end else if (load) begin
            opd_valid <= 1'b1;
        end else if (opd_ready) begin
            opd_valid <= 1'b0;
        end
    end

endmodule

`default_nettype wire

/* src/issue_scoreboard.sv */
`timescale 1ns/100ps
`default_nettype none

`include "issue_macros.svh"

module issue_scoreboard (
    input  wire                     clk,
    input  wire                     reset,

    input  wire [`ISSUE_WARPS-1:0]  head_valid,
    input  issue_pkg::decode_t      head_data [`ISSUE_WARPS],
    output logic [`ISSUE_WARPS-1:0] head_ready,

    input  wire                     writeback_valid,
    input  issue_pkg::writeback_t   writeback_data,

    output logic                    sched_valid,
    output issue_pkg::decode_t      sched_data,
    input  wire                     sched_ready
);
    logic [`ISSUE_REGS-1:0]      pending [`ISSUE_WARPS];
    logic [`ISSUE_WARPS-1:0]     eligible;
    logic [`ISSUE_WARP_BITS-1:0] last_wid;
    logic [`ISSUE_WARP_BITS-1:0] grant_wid;
    logic                        grant_valid;
    logic                        grant_fire;

    // A head waits while any register it touches is still owed a writeback
    always_comb begin
        for (int w = 0; w < `ISSUE_WARPS; w++) begin
            eligible[w] = head_valid[w]
                && !pending[w][head_data[w].rs1]
                && !pending[w][head_data[w].rs2]
                && !(head_data[w].wb && pending[w][head_data[w].rd]);
        end
    end

    // Round-robin search starting one past the last granted warp
    always_comb begin : rr_pick
        logic [`ISSUE_WARP_BITS-1:0] idx;
        grant_valid = 1'b0;
        grant_wid   = last_wid;
        for (int i = 1; i <= `ISSUE_WARPS; i++) begin
            idx = last_wid + `ISSUE_WARP_BITS'(i);
            if (!grant_valid && eligible[idx]) begin
                grant_valid = 1'b1;
                grant_wid   = idx;
            end
        end
    end

    assign grant_fire = grant_valid && (!sched_valid || sched_ready);

    always_comb begin
        for (int w = 0; w < `ISSUE_WARPS; w++) begin
            head_ready[w] = grant_fire && (grant_wid == `ISSUE_WARP_BITS'(w));
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int w = 0; w < `ISSUE_WARPS; w++) begin
                pending[w] <= '0;
            end
            last_wid    <= `ISSUE_WARP_BITS'(`ISSUE_WARPS - 1);
            sched_valid <= 1'b0;
        end else begin
            if (writeback_valid) begin
                pending[writeback_data.wid][writeback_data.rd] <= 1'b0;
            end
            // Set comes after clear so a same-edge grant keeps its claim
            if (grant_fire && head_data[grant_wid].wb) begin
                pending[grant_wid][head_data[grant_wid].rd] <= 1'b1;
            end
            if (grant_fire) begin
                last_wid    <= grant_wid;
                sched_valid <= 1'b1;
            end else if (sched_ready) begin
                sched_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (grant_fire) begin
            sched_data <= head_data[grant_wid];
        end
    end

endmodule

`default_nettype wire

/* src/issue_ibuffer.sv */
`timescale 1ns/100ps
`default_nettype none

`include "issue_macros.svh"

module issue_ibuffer (
    input  wire                  clk,
    input  wire                  reset,

    input  wire                  decode_valid,
    input  issue_pkg::decode_t   decode_data,
    output logic                 decode_ready,

    output logic [`ISSUE_WARPS-1:0] head_valid,
    output issue_pkg::decode_t   head_data [`ISSUE_WARPS],
    input  wire [`ISSUE_WARPS-1:0] head_ready
);
    localparam int PTR_BITS = $clog2(`ISSUE_IBUF_DEPTH);
    localparam int CNT_BITS = $clog2(`ISSUE_IBUF_DEPTH + 1);

    issue_pkg::decode_t  mem [`ISSUE_WARPS][`ISSUE_IBUF_DEPTH];
    logic [PTR_BITS-1:0] rd_ptr [`ISSUE_WARPS];
    logic [PTR_BITS-1:0] wr_ptr [`ISSUE_WARPS];
    logic [CNT_BITS-1:0] count  [`ISSUE_WARPS];
    logic                push;

    // Only the warp named by the incoming instruction matters for back-pressure
    assign decode_ready = (count[decode_data.wid] != CNT_BITS'(`ISSUE_IBUF_DEPTH));
    assign push = decode_valid && decode_ready;

    always_comb begin
        for (int w = 0; w < `ISSUE_WARPS; w++) begin
            head_valid[w] = (count[w] != '0);
            head_data[w]  = mem[w][rd_ptr[w]];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int w = 0; w < `ISSUE_WARPS; w++) begin
                rd_ptr[w] <= '0;
                wr_ptr[w] <= '0;
                count[w]  <= '0;
            end
        end else begin
            for (int w = 0; w < `ISSUE_WARPS; w++) begin
                logic do_push;
                logic do_pop;
                do_push = push && (decode_data.wid == `ISSUE_WARP_BITS'(w));
                do_pop  = head_valid[w] && head_ready[w];
                if (do_push) begin
                    wr_ptr[w] <= wr_ptr[w] + 1'b1;
                end
                if (do_pop) begin
                    rd_ptr[w] <= rd_ptr[w] + 1'b1;
                end
                if (do_push && !do_pop) begin
                    count[w] <= count[w] + 1'b1;
                end else if (do_pop && !do_push) begin
                    count[w] <= count[w] - 1'b1;
                end
            end
        end
    end

    // Storage write, steered by warp id
    always_ff @(posedge clk) begin
        if (push) begin
            mem[decode_data.wid][wr_ptr[decode_data.wid]] <= decode_data;
        end
    end

endmodule

`default_nettype wire

/* src/issue_pkg.sv */
`default_nettype none

`include "issue_macros.svh"

package issue_pkg;

    // Target execution unit, also used as the dispatch slot index
    typedef enum logic [0:0] {
        EX_ALU = 1'b0,
        EX_LSU = 1'b1
    } ex_type_t;

    typedef struct packed {
        logic [`ISSUE_UUID_BITS-1:0] uuid;
        logic [`ISSUE_WARP_BITS-1:0] wid;
        ex_type_t                    ex_type;
        // Opcode is not interpreted here and travels through unchanged
        logic [3:0]                  op_type;
        logic                        wb;
        logic [`ISSUE_REG_BITS-1:0]  rd;
        logic [`ISSUE_REG_BITS-1:0]  rs1;
        logic [`ISSUE_REG_BITS-1:0]  rs2;
    } decode_t;

    typedef struct packed {
        logic [`ISSUE_WARP_BITS-1:0] wid;
        logic [`ISSUE_REG_BITS-1:0]  rd;
        logic [`ISSUE_XLEN-1:0]      data;
    } writeback_t;

    typedef struct packed {
        decode_t                instr;
        logic [`ISSUE_XLEN-1:0] rs1_data;
        logic [`ISSUE_XLEN-1:0] rs2_data;
    } operands_t;

endpackage

`default_nettype wire

/* src/issue_macros.svh */
`ifndef ISSUE_MACROS_SVH
`define ISSUE_MACROS_SVH

// Core geometry
`define ISSUE_WARPS 4
`define ISSUE_WARP_BITS 2
`define ISSUE_REGS 32
`define ISSUE_REG_BITS 5
`define ISSUE_XLEN 32

// Per-warp instruction buffer and tag sizes
`define ISSUE_IBUF_DEPTH 4
`define ISSUE_UUID_BITS 8

`endif
